//--- logic/store_issue_consts.svh
`ifndef STORE_ISSUE_CONSTS_SVH
`define STORE_ISSUE_CONSTS_SVH

// Queue geometry
`define SIQ_BANK_NUM 4
`define SIQ_BANK_SIZE 4

// Field widths
`define SIQ_PREG_WIDTH 6
`define SIQ_ROB_WIDTH 5  // Slot index only, the wrap bit comes on top
`define SIQ_SQ_WIDTH 4
`define SIQ_IMM_WIDTH 12

`define SIQ_WB_NUM 2  // Writeback ports on the wakeup bus

`endif

//--- logic/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

    typedef enum logic [1:0] {
        ST_B,
        ST_H,
        ST_W
    } store_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } mem_size_e;

    function automatic mem_size_e to_size(input store_op_e op);
        case (op)
            ST_H: return SZ_HALF;
            ST_W: return SZ_WORD;
            default: return SZ_BYTE;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/issue_ctrl_pkg.sv
`default_nettype none
`include "store_issue_consts.svh"

package issue_ctrl_pkg;

    typedef enum logic [1:0] {
        ENT_FREE,
        ENT_WAIT,   // Holds a store with at least one source pending
        ENT_READY
    } entry_state_e;

    typedef struct packed {
        logic dir;  // Flips each time the ROB pointer wraps
        logic [`SIQ_ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    // True when a is younger than b
    function automatic logic rob_younger(input rob_idx_t a, input rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx > b.idx;
        end
        // Across a wrap the younger one sits at the lower slot
        return a.idx < b.idx;
    endfunction

endpackage

`default_nettype wire

//--- logic/store_dispatch_router.sv
`timescale 1ns/100ps
`default_nettype none
`include "store_issue_consts.svh"

module store_dispatch_router (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                dis_valid_i,
    input  logic [`SIQ_BANK_NUM-1:0][$clog2(`SIQ_BANK_SIZE):0] bank_count_i,
    input  logic [`SIQ_BANK_NUM-1:0]                            bank_full_i,
    output logic                                                dis_ready_o,
    output logic [`SIQ_BANK_NUM-1:0]                            bank_wr_en_o
);
    localparam int BANK_W = $clog2(`SIQ_BANK_NUM);

    logic [BANK_W-1:0]               pick_idx;
    logic [$clog2(`SIQ_BANK_SIZE):0] pick_cnt;
    logic [BANK_W-1:0]               target_q;
    logic                            target_vld_q;

    always_comb begin
        pick_idx = '0;
        pick_cnt = bank_count_i[0];
        for (int i = 1; i < `SIQ_BANK_NUM; i++) begin
            if (bank_count_i[i] < pick_cnt) begin  // Strict compare keeps ties on the lower bank
                pick_idx = BANK_W'(i);
                pick_cnt = bank_count_i[i];
            end
        end
    end

    // The choice lags the counts by one cycle, the full flags are current
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            target_q <= '0;
            target_vld_q <= 1'b0;
        end else begin
            target_q <= pick_idx;
            target_vld_q <= 1'b1;
        end
    end

    assign dis_ready_o = target_vld_q & ~bank_full_i[target_q];
    assign bank_wr_en_o = (dis_valid_i & dis_ready_o) ? (`SIQ_BANK_NUM'(1) << target_q) : '0;

    a_wr_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_wr_en_o));

endmodule

`default_nettype wire

//--- logic/store_issue_bank.sv
`timescale 1ns/100ps
`default_nettype none
`include "store_issue_consts.svh"

module store_issue_bank
    import mem_op_pkg::*;
    import issue_ctrl_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             wr_en_i,
    input  store_op_e                                        op_i,
    input  rob_idx_t                                         rob_idx_i,
    input  logic [`SIQ_SQ_WIDTH-1:0]                         sq_idx_i,
    input  logic [`SIQ_IMM_WIDTH-1:0]                        imm_i,
    input  logic [`SIQ_PREG_WIDTH-1:0]                       addr_preg_i,
    input  logic                                             addr_rdy_i,
    input  logic [`SIQ_PREG_WIDTH-1:0]                       data_preg_i,
    input  logic                                             data_rdy_i,
    input  logic [`SIQ_WB_NUM-1:0]                           wb_valid_i,
    input  logic [`SIQ_WB_NUM-1:0][`SIQ_PREG_WIDTH-1:0]      wb_preg_i,
    input  logic                                             redirect_i,
    input  rob_idx_t                                         redirect_rob_idx_i,
    input  logic                                             out_ready_i,
    output logic [$clog2(`SIQ_BANK_SIZE):0]                  count_o,
    output logic                                             full_o,
    output logic                                             out_valid_o,
    output store_op_e                                        out_op_o,
    output rob_idx_t                                         out_rob_idx_o,
    output logic [`SIQ_SQ_WIDTH-1:0]                         out_sq_idx_o,
    output logic [`SIQ_IMM_WIDTH-1:0]                        out_imm_o,
    output logic [`SIQ_PREG_WIDTH-1:0]                       out_addr_preg_o,
    output logic [`SIQ_PREG_WIDTH-1:0]                       out_data_preg_o
);
    localparam int IDX_W = $clog2(`SIQ_BANK_SIZE);
    localparam int CNT_W = IDX_W + 1;

    entry_state_e               state_q     [`SIQ_BANK_SIZE];
    logic [`SIQ_BANK_SIZE-1:0]  addr_rdy_q;
    logic [`SIQ_BANK_SIZE-1:0]  data_rdy_q;
    logic [`SIQ_BANK_SIZE-1:0]  addr_rdy_nxt;
    logic [`SIQ_BANK_SIZE-1:0]  data_rdy_nxt;
    store_op_e                  op_q        [`SIQ_BANK_SIZE];
    rob_idx_t                   rob_q       [`SIQ_BANK_SIZE];
    logic [`SIQ_SQ_WIDTH-1:0]   sq_q        [`SIQ_BANK_SIZE];
    logic [`SIQ_IMM_WIDTH-1:0]  imm_q       [`SIQ_BANK_SIZE];
    logic [`SIQ_PREG_WIDTH-1:0] addr_preg_q [`SIQ_BANK_SIZE];
    logic [`SIQ_PREG_WIDTH-1:0] data_preg_q [`SIQ_BANK_SIZE];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_any;
    logic             load;
    logic             wr_keep;
    logic             wr_addr_rdy;
    logic             wr_data_rdy;

    function automatic logic wake_hit(input logic [`SIQ_PREG_WIDTH-1:0] preg);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `SIQ_WB_NUM; p++) begin
            hit = hit | (wb_valid_i[p] && wb_preg_i[p] == preg);
        end
        return hit;
    endfunction

    // Downward scan so the lowest free and lowest ready slots win
    always_comb begin
        wr_idx = '0;
        sel_idx = '0;
        sel_any = 1'b0;
        full_o = 1'b1;
        count_o = '0;
        for (int i = `SIQ_BANK_SIZE - 1; i >= 0; i--) begin
            if (state_q[i] == ENT_FREE) begin
                wr_idx = IDX_W'(i);
                full_o = 1'b0;
            end else begin
                count_o = count_o + CNT_W'(1);
            end
            if (state_q[i] == ENT_READY) begin
                sel_idx = IDX_W'(i);
                sel_any = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SIQ_BANK_SIZE; i++) begin
            addr_rdy_nxt[i] = addr_rdy_q[i] | wake_hit(addr_preg_q[i]);
            data_rdy_nxt[i] = data_rdy_q[i] | wake_hit(data_preg_q[i]);
        end
        wr_addr_rdy = addr_rdy_i | wake_hit(addr_preg_i);  // Wakeup in the dispatch cycle counts
        wr_data_rdy = data_rdy_i | wake_hit(data_preg_i);
    end

    assign load = sel_any & (~out_valid_o | out_ready_i) & ~redirect_i;
    assign wr_keep = wr_en_i & ~(redirect_i & rob_younger(rob_idx_i, redirect_rob_idx_i));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SIQ_BANK_SIZE; i++) begin
                state_q[i] <= ENT_FREE;
            end
            addr_rdy_q <= '0;
            data_rdy_q <= '0;
        end else begin
            for (int i = 0; i < `SIQ_BANK_SIZE; i++) begin
                if (wr_keep && wr_idx == IDX_W'(i)) begin
                    state_q[i] <= (wr_addr_rdy && wr_data_rdy) ? ENT_READY : ENT_WAIT;
                    addr_rdy_q[i] <= wr_addr_rdy;
                    data_rdy_q[i] <= wr_data_rdy;
                end else if (state_q[i] != ENT_FREE && redirect_i
                             && rob_younger(rob_q[i], redirect_rob_idx_i)) begin
                    state_q[i] <= ENT_FREE;
                end else if (load && sel_idx == IDX_W'(i)) begin
                    state_q[i] <= ENT_FREE;  // Slot frees as the store moves out
                end else if (state_q[i] == ENT_WAIT) begin
                    addr_rdy_q[i] <= addr_rdy_nxt[i];
                    data_rdy_q[i] <= data_rdy_nxt[i];
                    if (addr_rdy_nxt[i] && data_rdy_nxt[i]) begin
                        state_q[i] <= ENT_READY;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            op_q[wr_idx] <= op_i;
            rob_q[wr_idx] <= rob_idx_i;
            sq_q[wr_idx] <= sq_idx_i;
            imm_q[wr_idx] <= imm_i;
            addr_preg_q[wr_idx] <= addr_preg_i;
            data_preg_q[wr_idx] <= data_preg_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= 1'b1;
        end else if ((out_valid_o && out_ready_i)
                     || (redirect_i && rob_younger(out_rob_idx_o, redirect_rob_idx_i))) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_op_o <= op_q[sel_idx];
            out_rob_idx_o <= rob_q[sel_idx];
            out_sq_idx_o <= sq_q[sel_idx];
            out_imm_o <= imm_q[sel_idx];
            out_addr_preg_o <= addr_preg_q[sel_idx];
            out_data_preg_o <= data_preg_q[sel_idx];
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en_i |-> !full_o);

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i && !redirect_i |=> out_valid_o && $stable(out_sq_idx_o));

endmodule

`default_nettype wire

//--- logic/store_issue_drain.sv
`timescale 1ns/100ps
`default_nettype none
`include "store_issue_consts.svh"

module store_issue_drain
    import mem_op_pkg::*;
    import issue_ctrl_pkg::*;
(
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [`SIQ_BANK_NUM-1:0]                        bank_valid_i,
    input  store_op_e [`SIQ_BANK_NUM-1:0]                   bank_op_i,
    input  rob_idx_t [`SIQ_BANK_NUM-1:0]                    bank_rob_idx_i,
    input  logic [`SIQ_BANK_NUM-1:0][`SIQ_SQ_WIDTH-1:0]     bank_sq_idx_i,
    input  logic [`SIQ_BANK_NUM-1:0][`SIQ_IMM_WIDTH-1:0]    bank_imm_i,
    input  logic [`SIQ_BANK_NUM-1:0][`SIQ_PREG_WIDTH-1:0]   bank_addr_preg_i,
    input  logic [`SIQ_BANK_NUM-1:0][`SIQ_PREG_WIDTH-1:0]   bank_data_preg_i,
    input  logic                                            redirect_i,
    input  rob_idx_t                                        redirect_rob_idx_i,
    input  logic                                            iss_ready_i,
    output logic [`SIQ_BANK_NUM-1:0]                        bank_ready_o,
    output logic                                            iss_valid_o,
    output store_op_e                                       iss_op_o,
    output mem_size_e                                       iss_size_o,
    output rob_idx_t                                        iss_rob_idx_o,
    output logic [`SIQ_SQ_WIDTH-1:0]                        iss_sq_idx_o,
    output logic [`SIQ_IMM_WIDTH-1:0]                       iss_imm_o,
    output logic [`SIQ_PREG_WIDTH-1:0]                      iss_addr_preg_o,
    output logic [`SIQ_PREG_WIDTH-1:0]                      iss_data_preg_o
);
    localparam int BANK_W = $clog2(`SIQ_BANK_NUM);

    logic [BANK_W-1:0] ptr_q;
    logic [BANK_W-1:0] gnt_idx;
    logic              gnt_any;
    logic              take;

    // First valid bank at or after the pointer, wrapping around
    always_comb begin
        logic [BANK_W-1:0] idx;
        gnt_idx = ptr_q;
        gnt_any = 1'b0;
        for (int k = `SIQ_BANK_NUM - 1; k >= 0; k--) begin
            idx = BANK_W'(ptr_q + k);
            if (bank_valid_i[idx]) begin
                gnt_idx = idx;
                gnt_any = 1'b1;
            end
        end
    end

    // No grant in a redirect cycle, the bank squashes its own younger store
    assign take = gnt_any & (~iss_valid_o | iss_ready_i) & ~redirect_i;
    assign bank_ready_o = take ? (`SIQ_BANK_NUM'(1) << gnt_idx) : '0;
    assign iss_size_o = to_size(iss_op_o);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
            iss_valid_o <= 1'b0;
        end else begin
            if (take) begin
                ptr_q <= gnt_idx + 1'b1;
                iss_valid_o <= 1'b1;
            end else if ((iss_valid_o && iss_ready_i)
                         || (redirect_i && rob_younger(iss_rob_idx_o, redirect_rob_idx_i))) begin
                iss_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            iss_op_o <= bank_op_i[gnt_idx];
            iss_rob_idx_o <= bank_rob_idx_i[gnt_idx];
            iss_sq_idx_o <= bank_sq_idx_i[gnt_idx];
            iss_imm_o <= bank_imm_i[gnt_idx];
            iss_addr_preg_o <= bank_addr_preg_i[gnt_idx];
            iss_data_preg_o <= bank_data_preg_i[gnt_idx];
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_ready_o));

endmodule

`default_nettype wire

//--- logic/store_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "store_issue_consts.svh"

module store_issue_queue
    import mem_op_pkg::*;
    import issue_ctrl_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        dis_valid_i,
    output logic                                        dis_ready_o,
    input  store_op_e                                   dis_op_i,
    input  rob_idx_t                                    dis_rob_idx_i,
    input  logic [`SIQ_SQ_WIDTH-1:0]                    dis_sq_idx_i,
    input  logic [`SIQ_IMM_WIDTH-1:0]                   dis_imm_i,
    input  logic [`SIQ_PREG_WIDTH-1:0]                  dis_addr_preg_i,
    input  logic                                        dis_addr_rdy_i,
    input  logic [`SIQ_PREG_WIDTH-1:0]                  dis_data_preg_i,
    input  logic                                        dis_data_rdy_i,
    input  logic [`SIQ_WB_NUM-1:0]                      wb_valid_i,
    input  logic [`SIQ_WB_NUM-1:0][`SIQ_PREG_WIDTH-1:0] wb_preg_i,
    input  logic                                        redirect_i,
    input  rob_idx_t                                    redirect_rob_idx_i,
    output logic                                        iss_valid_o,
    input  logic                                        iss_ready_i,
    output store_op_e                                   iss_op_o,
    output mem_size_e                                   iss_size_o,
    output rob_idx_t                                    iss_rob_idx_o,
    output logic [`SIQ_SQ_WIDTH-1:0]                    iss_sq_idx_o,
    output logic [`SIQ_IMM_WIDTH-1:0]                   iss_imm_o,
    output logic [`SIQ_PREG_WIDTH-1:0]                  iss_addr_preg_o,
    output logic [`SIQ_PREG_WIDTH-1:0]                  iss_data_preg_o
);
    logic [`SIQ_BANK_NUM-1:0][$clog2(`SIQ_BANK_SIZE):0]  bank_count;
    logic [`SIQ_BANK_NUM-1:0]                           bank_full;
    logic [`SIQ_BANK_NUM-1:0]                           bank_wr_en;
    logic [`SIQ_BANK_NUM-1:0]                           bank_out_valid;
    logic [`SIQ_BANK_NUM-1:0]                           bank_out_ready;
    store_op_e [`SIQ_BANK_NUM-1:0]                      bank_out_op;
    rob_idx_t [`SIQ_BANK_NUM-1:0]                       bank_out_rob_idx;
    logic [`SIQ_BANK_NUM-1:0][`SIQ_SQ_WIDTH-1:0]        bank_out_sq_idx;
    logic [`SIQ_BANK_NUM-1:0][`SIQ_IMM_WIDTH-1:0]       bank_out_imm;
    logic [`SIQ_BANK_NUM-1:0][`SIQ_PREG_WIDTH-1:0]      bank_out_addr_preg;
    logic [`SIQ_BANK_NUM-1:0][`SIQ_PREG_WIDTH-1:0]      bank_out_data_preg;

    store_dispatch_router u_router (
        .clk          (clk),
        .rst          (rst),
        .dis_valid_i  (dis_valid_i),
        .bank_count_i (bank_count),
        .bank_full_i  (bank_full),
        .dis_ready_o  (dis_ready_o),
        .bank_wr_en_o (bank_wr_en)
    );

    // Dispatch fields reach every bank, only the enabled one writes
    for (genvar g = 0; g < `SIQ_BANK_NUM; g++) begin : g_bank
        store_issue_bank u_bank (
            .clk                (clk),
            .rst                (rst),
            .wr_en_i            (bank_wr_en[g]),
            .op_i               (dis_op_i),
            .rob_idx_i          (dis_rob_idx_i),
            .sq_idx_i           (dis_sq_idx_i),
            .imm_i              (dis_imm_i),
            .addr_preg_i        (dis_addr_preg_i),
            .addr_rdy_i         (dis_addr_rdy_i),
            .data_preg_i        (dis_data_preg_i),
            .data_rdy_i         (dis_data_rdy_i),
            .wb_valid_i         (wb_valid_i),
            .wb_preg_i          (wb_preg_i),
            .redirect_i         (redirect_i),
            .redirect_rob_idx_i (redirect_rob_idx_i),
            .out_ready_i        (bank_out_ready[g]),
            .count_o            (bank_count[g]),
            .full_o             (bank_full[g]),
            .out_valid_o        (bank_out_valid[g]),
            .out_op_o           (bank_out_op[g]),
            .out_rob_idx_o      (bank_out_rob_idx[g]),
            .out_sq_idx_o       (bank_out_sq_idx[g]),
            .out_imm_o          (bank_out_imm[g]),
            .out_addr_preg_o    (bank_out_addr_preg[g]),
            .out_data_preg_o    (bank_out_data_preg[g])
        );
    end

    store_issue_drain u_drain (
        .clk                (clk),
        .rst                (rst),
        .bank_valid_i       (bank_out_valid),
        .bank_op_i          (bank_out_op),
        .bank_rob_idx_i     (bank_out_rob_idx),
        .bank_sq_idx_i      (bank_out_sq_idx),
        .bank_imm_i         (bank_out_imm),
        .bank_addr_preg_i   (bank_out_addr_preg),
        .bank_data_preg_i   (bank_out_data_preg),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .iss_ready_i        (iss_ready_i),
        .bank_ready_o       (bank_out_ready),
        .iss_valid_o        (iss_valid_o),
        .iss_op_o           (iss_op_o),
        .iss_size_o         (iss_size_o),
        .iss_rob_idx_o      (iss_rob_idx_o),
        .iss_sq_idx_o       (iss_sq_idx_o),
        .iss_imm_o          (iss_imm_o),
        .iss_addr_preg_o    (iss_addr_preg_o),
        .iss_data_preg_o    (iss_data_preg_o)
    );

endmodule

`default_nettype wire

//--- sim/store_issue_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "store_issue_consts.svh"

module store_issue_tb
    import mem_op_pkg::*;
    import issue_ctrl_pkg::*;
();
    localparam int PERIOD = 40;
    localparam int RAND_CYCLES = 800;
    localparam int DRAIN_LIMIT = 200;
    localparam int TEST_CYCLES = RAND_CYCLES + 3 * DRAIN_LIMIT + 20;
    localparam int SQ_NUM = 1 << `SIQ_SQ_WIDTH;
    localparam int CAP = `SIQ_BANK_NUM * `SIQ_BANK_SIZE;
    localparam int RW = `SIQ_ROB_WIDTH + 1;  // Wrap bit plus slot
    localparam int SQW = `SIQ_SQ_WIDTH;
    localparam int PW = `SIQ_PREG_WIDTH;
    localparam int IW = `SIQ_IMM_WIDTH;

    logic clk;
    logic rst;
    logic dis_valid;
    logic dis_ready;
    store_op_e dis_op;
    rob_idx_t dis_rob;
    logic [SQW-1:0] dis_sq;
    logic [IW-1:0] dis_imm;
    logic [PW-1:0] dis_addr_preg;
    logic dis_addr_rdy;
    logic [PW-1:0] dis_data_preg;
    logic dis_data_rdy;
    logic [`SIQ_WB_NUM-1:0] wb_valid;
    logic [`SIQ_WB_NUM-1:0][PW-1:0] wb_preg;
    logic redirect;
    rob_idx_t redirect_rob;
    logic iss_valid;
    logic iss_ready;
    store_op_e iss_op;
    mem_size_e iss_size;
    rob_idx_t iss_rob;
    logic [SQW-1:0] iss_sq;
    logic [IW-1:0] iss_imm;
    logic [PW-1:0] iss_addr_preg;
    logic [PW-1:0] iss_data_preg;

    // One scoreboard slot per store-queue index
    logic sb_live [SQ_NUM];
    logic sb_flushed [SQ_NUM];
    logic sb_aw [SQ_NUM];
    logic sb_dw [SQ_NUM];
    store_op_e sb_op [SQ_NUM];
    logic [RW-1:0] sb_rob [SQ_NUM];
    logic [IW-1:0] sb_imm [SQ_NUM];
    logic [PW-1:0] sb_addr_preg [SQ_NUM];
    logic [PW-1:0] sb_data_preg [SQ_NUM];

    int errors;
    logic [31:0] rng;
    logic [RW-1:0] rob_next;
    logic fill_done;

    store_issue_queue UUT (
        .clk(clk), .rst(rst),
        .dis_valid_i(dis_valid), .dis_ready_o(dis_ready),
        .dis_op_i(dis_op), .dis_rob_idx_i(dis_rob), .dis_sq_idx_i(dis_sq),
        .dis_imm_i(dis_imm), .dis_addr_preg_i(dis_addr_preg),
        .dis_addr_rdy_i(dis_addr_rdy), .dis_data_preg_i(dis_data_preg),
        .dis_data_rdy_i(dis_data_rdy), .wb_valid_i(wb_valid), .wb_preg_i(wb_preg),
        .redirect_i(redirect), .redirect_rob_idx_i(redirect_rob),
        .iss_valid_o(iss_valid), .iss_ready_i(iss_ready), .iss_op_o(iss_op),
        .iss_size_o(iss_size), .iss_rob_idx_o(iss_rob), .iss_sq_idx_o(iss_sq),
        .iss_imm_o(iss_imm), .iss_addr_preg_o(iss_addr_preg),
        .iss_data_preg_o(iss_data_preg)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // Same wrap bit means larger slot is younger, otherwise smaller slot
    function automatic logic is_younger(input logic [RW-1:0] a, input logic [RW-1:0] b);
        if (a[RW-1] == b[RW-1]) begin
            return a[RW-2:0] > b[RW-2:0];
        end
        return a[RW-2:0] < b[RW-2:0];
    endfunction

    function automatic mem_size_e size_of(input store_op_e op);
        case (op)
            ST_B: return SZ_BYTE;
            ST_H: return SZ_HALF;
            default: return SZ_WORD;
        endcase
    endfunction

    function automatic logic wake_match(input logic [PW-1:0] preg);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `SIQ_WB_NUM; p++) begin
            hit = hit | (wb_valid[p] && wb_preg[p] == preg);
        end
        return hit;
    endfunction

    function automatic void report_value(input string name, input logic [31:0] got,
                                         input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s got %h expected %h", name, got, exp);
    endfunction

    // Wait one edge and fold what happened in the elapsed cycle into the scoreboard
    task automatic next_cycle(output logic acc);
        @(posedge clk);
        acc = dis_valid && dis_ready;
        if (iss_valid && iss_ready) begin
            sb_live[iss_sq] = 1'b0;
        end
        for (int s = 0; s < SQ_NUM; s++) begin
            if (redirect && sb_live[s] && is_younger(sb_rob[s], redirect_rob)) begin
                sb_live[s] = 1'b0;
                sb_flushed[s] = 1'b1;
            end
            if (sb_live[s] && wake_match(sb_addr_preg[s])) begin
                sb_aw[s] = 1'b1;
            end
            if (sb_live[s] && wake_match(sb_data_preg[s])) begin
                sb_dw[s] = 1'b1;
            end
        end
        if (acc) begin
            rob_next = dis_rob + RW'(1);
            if (!(redirect && is_younger(dis_rob, redirect_rob))) begin
                sb_live[dis_sq] = 1'b1;
                sb_flushed[dis_sq] = 1'b0;
                sb_aw[dis_sq] = dis_addr_rdy | wake_match(dis_addr_preg);
                sb_dw[dis_sq] = dis_data_rdy | wake_match(dis_data_preg);
                sb_op[dis_sq] = dis_op;
                sb_rob[dis_sq] = dis_rob;
                sb_imm[dis_sq] = dis_imm;
                sb_addr_preg[dis_sq] = dis_addr_preg;
                sb_data_preg[dis_sq] = dis_data_preg;
            end
        end
    endtask

    task automatic free_sq(output logic found, output logic [SQW-1:0] idx);
        found = 1'b0;
        idx = '0;
        for (int s = SQ_NUM - 1; s >= 0; s--) begin
            if (!sb_live[s]) begin
                found = 1'b1;
                idx = SQW'(s);
            end
        end
    endtask

    task automatic launch(input logic [SQW-1:0] s, input logic [31:0] r);
        dis_valid <= 1'b1;
        dis_sq <= s;
        dis_rob <= rob_next;
        dis_op <= store_op_e'(r[7:0] % 3);
        dis_imm <= r[19:8];
        dis_addr_preg <= r[25:20];
        dis_data_preg <= r[31:26];
        dis_addr_rdy <= r[3];
        dis_data_rdy <= r[10];
    endtask

    // Wake a pending source of two randomly picked live stores
    task automatic wake_pending();
        logic [31:0] r;
        logic [SQW-1:0] s;
        draw(r);
        for (int p = 0; p < `SIQ_WB_NUM; p++) begin
            s = r[p*8 +: SQW];
            wb_valid[p] <= sb_live[s];
            wb_preg[p] <= sb_aw[s] ? sb_data_preg[s] : sb_addr_preg[s];
        end
    endtask

    task automatic random_cycle();
        logic acc;
        logic [31:0] r;
        logic found;
        logic [SQW-1:0] s;
        next_cycle(acc);
        draw(r);
        iss_ready <= r[1:0] != 2'b00;
        if (r[8:4] == 5'd0) begin
            redirect <= 1'b1;
            redirect_rob <= rob_next - RW'(1) - RW'(r[10:9]);
            rob_next = rob_next - RW'(r[10:9]);
            dis_valid <= 1'b0;  // A held store is dropped, the frontend refetches
        end else begin
            redirect <= 1'b0;
            if (!dis_valid || acc) begin
                free_sq(found, s);
                draw(r);
                if (found && r[0]) begin
                    launch(s, r);
                end else begin
                    dis_valid <= 1'b0;
                end
            end
        end
        wake_pending();
        draw(r);
        if (r[0]) begin
            wb_valid[1] <= 1'b1;
            wb_preg[1] <= r[PW:1];
        end
    endtask

    task automatic drain_all();
        logic acc;
        int cycles;
        int live;
        dis_valid <= 1'b0;
        redirect <= 1'b0;
        iss_ready <= 1'b1;
        cycles = 0;
        live = 1;
        while ((live != 0 || iss_valid) && cycles < DRAIN_LIMIT) begin
            next_cycle(acc);
            wake_pending();
            cycles++;
            live = 0;
            for (int s = 0; s < SQ_NUM; s++) begin
                live += int'(sb_live[s]);
            end
        end
        if (live != 0) begin
            errors++;
            $display("Stores still waiting after %0d drain cycles", DRAIN_LIMIT);
        end
    endtask

    // Dispatch a full queue with unready sources and no wakeups
    task automatic fill_queue();
        logic acc;
        logic found;
        logic [SQW-1:0] s;
        logic [31:0] r;
        int n;
        int cycles;
        n = 0;
        cycles = 0;
        wb_valid <= '0;
        while (n < CAP && cycles < DRAIN_LIMIT) begin
            next_cycle(acc);
            cycles++;
            if (acc) begin
                n++;
            end
            if (!dis_valid || acc) begin
                free_sq(found, s);
                draw(r);
                if (found) begin
                    launch(s, r);
                    dis_addr_preg <= PW'(2 * s);
                    dis_data_preg <= PW'(2 * s + 1);
                    dis_addr_rdy <= 1'b0;
                    dis_data_rdy <= 1'b0;
                end else begin
                    dis_valid <= 1'b0;
                end
            end
        end
        if (n < CAP) begin
            errors++;
            $display("Only %0d of %0d stores were accepted into an idle queue", n, CAP);
        end
        fill_done = 1'b1;
        repeat (3) next_cycle(acc);
        fill_done = 1'b0;
    endtask

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !iss_valid)
        else report_value("iss_valid_o", 32'($sampled(iss_valid)), 32'h0);
    a_ready_up: assert property (@(posedge clk) $fell(rst) |=> dis_ready)
        else begin
            errors++;
            $display("dis_ready_o did not rise after reset");
        end
    a_live: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> sb_live[iss_sq])
        else begin
            errors++;
            $display("Issued sq %0h is not a waiting store", $sampled(iss_sq));
        end
    a_not_flushed: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> !sb_flushed[iss_sq])
        else begin
            errors++;
            $display("Flushed store sq %0h was issued", $sampled(iss_sq));
        end
    a_srcs_ready: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> sb_aw[iss_sq] && sb_dw[iss_sq])
        else begin
            errors++;
            $display("Store sq %0h issued before its sources", $sampled(iss_sq));
        end
    a_op: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> iss_op == sb_op[iss_sq])
        else report_value("iss_op_o", 32'($sampled(iss_op)), 32'($sampled(sb_op[iss_sq])));
    a_size: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> iss_size == size_of(sb_op[iss_sq]))
        else report_value("iss_size_o", 32'($sampled(iss_size)),
                          32'(size_of($sampled(sb_op[iss_sq]))));
    a_rob: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> iss_rob == sb_rob[iss_sq])
        else report_value("iss_rob_idx_o", 32'($sampled(iss_rob)),
                          32'($sampled(sb_rob[iss_sq])));
    a_imm: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> iss_imm == sb_imm[iss_sq])
        else report_value("iss_imm_o", 32'($sampled(iss_imm)), 32'($sampled(sb_imm[iss_sq])));
    a_addr: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> iss_addr_preg == sb_addr_preg[iss_sq])
        else report_value("iss_addr_preg_o", 32'($sampled(iss_addr_preg)),
                          32'($sampled(sb_addr_preg[iss_sq])));
    a_data: assert property (@(posedge clk) disable iff (rst)
        iss_valid && iss_ready |-> iss_data_preg == sb_data_preg[iss_sq])
        else report_value("iss_data_preg_o", 32'($sampled(iss_data_preg)),
                          32'($sampled(sb_data_preg[iss_sq])));
    a_hold: assert property (@(posedge clk) disable iff (rst)
        iss_valid && !iss_ready && !redirect |=> iss_valid && $stable(iss_op)
            && $stable(iss_rob) && $stable(iss_sq) && $stable(iss_imm)
            && $stable(iss_addr_preg) && $stable(iss_data_preg) && $stable(iss_size))
        else begin
            errors++;
            $display("Issue outputs changed while stalled");
        end
    a_full_stall: assert property (@(posedge clk) disable iff (rst) fill_done |-> !dis_ready)
        else report_value("dis_ready_o", 32'($sampled(dis_ready)), 32'h0);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 4 * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst = 1'b1;
        dis_valid = 1'b0;
        dis_op = ST_B;
        dis_rob = '0;
        dis_sq = '0;
        dis_imm = '0;
        dis_addr_preg = '0;
        dis_addr_rdy = 1'b0;
        dis_data_preg = '0;
        dis_data_rdy = 1'b0;
        wb_valid = '0;
        wb_preg = '0;
        redirect = 1'b0;
        redirect_rob = '0;
        iss_ready = 1'b0;
        errors = 0;
        rng = 32'h757a225d;
        rob_next = '0;
        fill_done = 1'b0;
        for (int s = 0; s < SQ_NUM; s++) begin
            sb_live[s] = 1'b0;
            sb_flushed[s] = 1'b0;
            sb_aw[s] = 1'b0;
            sb_dw[s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (RAND_CYCLES) random_cycle();
        drain_all();
        fill_queue();
        drain_all();
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/mem_op_pkg.sv
logic/issue_ctrl_pkg.sv
logic/store_dispatch_router.sv
logic/store_issue_bank.sv
logic/store_issue_drain.sv
logic/store_issue_queue.sv
sim/store_issue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= store_issue_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module store_issue_queue

clean:
	rm -rf $(BUILD_DIR) $(LOG)
